// ==== files.f ====
+incdir+.
morse_pkg.sv
seg_pkg.sv
morse_tick_gen.sv
morse_keyer.sv
morse_decoder.sv
hex_ticker.sv
morse_top.sv
tb_clock_gen.sv
tb_morse_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Morse decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	-f files.f --top-module tb_morse_top -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"

// ==== tb_morse_top.sv ====
//////////////////////////////
// Testbench for the Morse key decoder
// Letter table, keying tasks, compare tasks, watchdog
//////////////////////////////
`include "morse_settings.svh"

module tb_morse_top;
	timeunit 1ns;
	timeprecision 100ps;
	import morse_pkg::*;
	import seg_pkg::*;

	localparam int TB_TICK_DIV = 4;
	localparam int CLK_NS      = 40;
	localparam int DOT_TICKS   = 2;
	localparam int DASH_TICKS  = 7;
	localparam int SYM_GAP     = 2; // Key up between symbols
	localparam int END_GAP     = 8; // Key up closing a letter
	localparam int N_ROWS      = 23;

	typedef struct packed {
		logic [7:0]  name; // ASCII label
		logic [5:0]  syms; // Bit i is symbol i with 1 for a dash
		logic [2:0]  len;
		char_code_t  code;
		press_mark_t mark; // Class of the last press
	} row_t;

	localparam press_mark_t SHORT = '{is_long: 1'b0, is_short: 1'b1};
	localparam press_mark_t LONG  = '{is_long: 1'b1, is_short: 1'b0};

	////////////////////////////// Letter table

	localparam row_t ROWS [N_ROWS] = '{
		'{"E", 6'b000000, 3'd1, 6'd14, SHORT},      // .
		'{"T", 6'b000001, 3'd1, 6'd29, LONG},       // -
		'{"A", 6'b000010, 3'd2, 6'd10, LONG},       // .-
		'{"N", 6'b000001, 3'd2, 6'd23, SHORT},      // -.
		'{"S", 6'b000000, 3'd3, 6'd28, SHORT},      // ...
		'{"K", 6'b000101, 3'd3, 6'd20, LONG},       // -.-
		'{"W", 6'b000110, 3'd3, 6'd32, LONG},       // .--
		'{"H", 6'b000000, 3'd4, 6'd17, SHORT},      // ....
		'{"C", 6'b000101, 3'd4, 6'd12, SHORT},      // -.-.
		'{"Q", 6'b001011, 3'd4, 6'd26, LONG},       // --.-
		'{"Z", 6'b000011, 3'd4, 6'd35, SHORT},      // --..
		'{"0", 6'b011111, 3'd5, 6'd0, LONG},        // -----
		'{"1", 6'b011110, 3'd5, 6'd1, LONG},        // .----
		'{"2", 6'b011100, 3'd5, 6'd2, LONG},        // ..---
		'{"3", 6'b011000, 3'd5, 6'd3, LONG},        // ...--
		'{"4", 6'b010000, 3'd5, 6'd4, LONG},        // ....-
		'{"5", 6'b000000, 3'd5, 6'd5, SHORT},       // .....
		'{"6", 6'b000001, 3'd5, 6'd6, SHORT},       // -....
		'{"7", 6'b000011, 3'd5, 6'd7, SHORT},       // --...
		'{"8", 6'b000111, 3'd5, 6'd8, SHORT},       // ---..
		'{"9", 6'b001111, 3'd5, 6'd9, SHORT},       // ----.
		'{"?", 6'b001111, 3'd4, CHAR_BLANK, LONG},  // ---- unmapped
		'{"5", 6'b000000, 3'd6, 6'd5, SHORT}        // ...... sixth dot dropped
	};

	// Own glyph copy in active-low form with a on bit 0
	localparam seg_t GLYPHS [37] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, // 0..4
		7'h12, 7'h02, 7'h78, 7'h00, 7'h10, // 5..9
		7'h08, 7'h03, 7'h46, 7'h21, 7'h06, // A..E
		7'h0E, 7'h42, 7'h09, 7'h4F, 7'h61, // F..J
		7'h0A, 7'h47, 7'h6A, 7'h2B, 7'h23, // K..O
		7'h0C, 7'h18, 7'h2F, 7'h12, 7'h07, // P..T
		7'h41, 7'h63, 7'h55, 7'h09, 7'h11, // U..Y
		7'h24, 7'h7F                       // Z, blank
	};

	logic        CLOCK_50;
	logic        rst_n;
	logic        key;
	hex_bank_t   hex;
	press_mark_t ledr;
	char_code_t  model [`HEX_DIGITS]; // Newest at 0
	int          order [N_ROWS];
	int          errors;
	int          row_errors;
	int          rows_failed;

	tb_clock_gen clk0 (.CLOCK_50(CLOCK_50), .rst_n(rst_n));

	morse_top #(.tick_div(TB_TICK_DIV)) dut0 (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.key      (key),
		.hex      (hex),
		.ledr     (ledr)
	);

	////////////////////////////// Helpers

	// Any 4*n consecutive edges hold exactly n ticks
	task automatic hold_key(input logic level, input int ticks);
		@(posedge CLOCK_50);
		key <= level;
		repeat (ticks * TB_TICK_DIV - 1) @(posedge CLOCK_50);
	endtask

	task automatic key_letter(input row_t r);
		for (int i = 0; i < int'(r.len); i++) begin
			if (i > 0)
				hold_key(1'b1, SYM_GAP);
			hold_key(1'b0, r.syms[i] ? DASH_TICKS : DOT_TICKS);
		end
		hold_key(1'b1, END_GAP);
		hold_key(1'b1, 1); // One more tick before checking
	endtask

	function automatic int row_ticks(input row_t r);
		int t;
		t = END_GAP + 1;
		for (int i = 0; i < int'(r.len); i++) begin
			t += r.syms[i] ? DASH_TICKS : DOT_TICKS;
			if (i > 0)
				t += SYM_GAP;
		end
		return t;
	endfunction

	// Fisher-Yates over order[lo..hi]
	task automatic shuffle_span(input int lo, input int hi);
		int j;
		int tmp;
		for (int i = hi; i > lo; i--) begin
			j = lo + int'($urandom % unsigned'(i - lo + 1));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
	endtask

	function automatic hex_bank_t expected_bank();
		hex_bank_t b;
		for (int i = 0; i < `HEX_DIGITS; i++)
			b[i] = GLYPHS[model[i]];
		return b;
	endfunction

	task automatic check_hex(input hex_bank_t expected, input hex_bank_t actual);
		if (actual !== expected) begin
			$display("Error at %0d ns: hex expected %h, got %h", $time, expected, actual);
			errors++;
			row_errors++;
		end
	endtask

	task automatic check_mark(input press_mark_t expected, input press_mark_t actual);
		if (actual !== expected) begin
			$display("Error at %0d ns: ledr expected %b, got %b", $time, expected, actual);
			errors++;
			row_errors++;
		end
	endtask

	////////////////////////////// Main sequence

	initial begin : main
		row_t        r;
		key         = 1'b1; // Button up
		errors      = 0;
		rows_failed = 0;
		void'($urandom(32'hd618_ddc8));
		for (int i = 0; i < N_ROWS; i++)
			order[i] = i;
		shuffle_span(2, 10);  // Letter set
		shuffle_span(11, 20); // Digit set
		for (int i = 0; i < `HEX_DIGITS; i++)
			model[i] = CHAR_BLANK;

		wait (rst_n === 1'b1);
		@(negedge CLOCK_50);
		row_errors = 0;
		check_hex(expected_bank(), hex); // Dark display
		check_mark('0, ledr);
		if (row_errors != 0)
			rows_failed++;
		$display("Test 0 reset state: %s", (row_errors == 0) ? "ok" : "mismatch");

		// Model shift also covers drop of the oldest digit
		for (int n = 0; n < N_ROWS; n++) begin
			r = ROWS[order[n]];
			row_errors = 0;
			key_letter(r);
			for (int i = `HEX_DIGITS - 1; i > 0; i--)
				model[i] = model[i-1];
			model[0] = r.code;
			@(negedge CLOCK_50);
			check_hex(expected_bank(), hex);
			check_mark(r.mark, ledr);
			if (row_errors != 0)
				rows_failed++;
			$display("Test %0d letter %c code %0d: %s", n + 1, r.name, r.code,
				(row_errors == 0) ? "ok" : "mismatch");
		end

		$display("Summary: %0d tests, %0d failed, %0d check errors",
			N_ROWS + 1, rows_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	////////////////////////////// Watchdog

	initial begin : watchdog
		int     longest;
		longint limit_ns;
		longest = 0;
		for (int i = 0; i < N_ROWS; i++)
			if (row_ticks(ROWS[i]) > longest)
				longest = row_ticks(ROWS[i]);
		limit_ns = longint'(N_ROWS) * longest * TB_TICK_DIV * CLK_NS * 2;
		#(limit_ns);
		$display("Watchdog: run did not finish within %0d ns", limit_ns);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb_clock_gen.sv ====
//////////////////////////////
// Testbench clock and reset source
//////////////////////////////

module tb_clock_gen #(
	parameter int half_period  = 20, // 40 ns period
	parameter int reset_cycles = 3
) (
	output logic CLOCK_50,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLOCK_50 = 1'b0;
		forever #(half_period) CLOCK_50 = ~CLOCK_50;
	end

	// Low over the first few rising edges, released on an edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge CLOCK_50);
		rst_n <= 1'b1;
	end

endmodule

// ==== morse_top.sv ====
//////////////////////////////
// Morse key decoder top level
//////////////////////////////
`include "morse_settings.svh"

module morse_top #(
	parameter int unsigned tick_div = `MORSE_TICK_DIV
) (
	input  logic                   CLOCK_50,
	input  logic                   rst_n,
	input  logic                   key,  // Button, active low
	output seg_pkg::hex_bank_t     hex,
	output morse_pkg::press_mark_t ledr  // Short/long of last press
);
	import morse_pkg::*;

	logic       tick;
	letter_t    letter;
	logic       letter_done;
	char_code_t code;
	logic       code_valid;

	// Keying clock enable
	morse_tick_gen #(
		.tick_div (tick_div)
	) u_tick_gen (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.tick     (tick)
	);

	morse_keyer u_keyer (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.tick        (tick),
		.key         (key),
		.letter      (letter),
		.letter_done (letter_done),
		.mark        (ledr)
	);

	morse_decoder u_decoder (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.letter      (letter),
		.letter_done (letter_done),
		.code        (code),
		.code_valid  (code_valid)
	);

	// Newest letter on HEX0
	hex_ticker u_ticker (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.code       (code),
		.code_valid (code_valid),
		.hex        (hex)
	);

endmodule

// ==== hex_ticker.sv ====
//////////////////////////////
// Six-digit scrolling display
// Code shift register and font lookup per digit
//////////////////////////////
`include "morse_settings.svh"

module hex_ticker (
	input  logic                  CLOCK_50,
	input  logic                  rst_n,
	input  morse_pkg::char_code_t code,
	input  logic                  code_valid,
	output seg_pkg::hex_bank_t    hex
);
	import morse_pkg::*;
	import seg_pkg::*;

	// Position 0 is newest, shown on HEX0
	char_code_t digits [`HEX_DIGITS];

	////////////////////////////// Shift

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			for (int i = 0; i < `HEX_DIGITS; i++)
				digits[i] <= CHAR_BLANK; // Dark display
		end else if (code_valid) begin
			// Oldest falls off HEX5
			for (int i = `HEX_DIGITS - 1; i > 0; i--)
				digits[i] <= digits[i-1];
			digits[0] <= code;
		end
	end

	////////////////////////////// Font

	always_comb begin
		for (int i = 0; i < `HEX_DIGITS; i++) begin
			if (digits[i] > CHAR_BLANK)
				hex[i] = FONT[CHAR_BLANK]; // Out of table
			else
				hex[i] = FONT[digits[i]];
		end
	end

endmodule

// ==== morse_decoder.sv ====
//////////////////////////////
// Pattern to character code lookup, registered
//////////////////////////////

module morse_decoder (
	input  logic                  CLOCK_50,
	input  logic                  rst_n,
	input  morse_pkg::letter_t    letter,
	input  logic                  letter_done,
	output morse_pkg::char_code_t code,
	output logic                  code_valid
);
	import morse_pkg::*;

	char_code_t lookup;

	// International Morse, bit 0 keyed first
	always_comb begin
		lookup = CHAR_BLANK; // Unmapped shapes go dark
		case (letter.count)
			3'd1: lookup = letter.pattern[0] ? 6'd29 : 6'd14; // T or E
			3'd2: begin
				case (letter.pattern[1:0])
					2'b10: lookup = 6'd10; // A
					2'b00: lookup = 6'd18; // I
					2'b11: lookup = 6'd22; // M
					2'b01: lookup = 6'd23; // N
				endcase
			end
			3'd3: begin
				case (letter.pattern[2:0])
					3'b000: lookup = 6'd28; // S
					3'b100: lookup = 6'd30; // U
					3'b001: lookup = 6'd13; // D
					3'b011: lookup = 6'd16; // G
					3'b101: lookup = 6'd20; // K
					3'b111: lookup = 6'd24; // O
					3'b010: lookup = 6'd27; // R
					3'b110: lookup = 6'd32; // W
				endcase
			end
			3'd4: begin
				case (letter.pattern[3:0])
					4'b0000: lookup = 6'd17; // H
					4'b0001: lookup = 6'd11; // B
					4'b0101: lookup = 6'd12; // C
					4'b0100: lookup = 6'd15; // F
					4'b1110: lookup = 6'd19; // J
					4'b0010: lookup = 6'd21; // L
					4'b0110: lookup = 6'd25; // P
					4'b1011: lookup = 6'd26; // Q
					4'b1000: lookup = 6'd31; // V
					4'b1001: lookup = 6'd33; // X
					4'b1101: lookup = 6'd34; // Y
					4'b0011: lookup = 6'd35; // Z
					default: lookup = CHAR_BLANK;
				endcase
			end
			3'd5: begin // Digits only
				case (letter.pattern)
					5'b11111: lookup = 6'd0;
					5'b11110: lookup = 6'd1;
					5'b11100: lookup = 6'd2;
					5'b11000: lookup = 6'd3;
					5'b10000: lookup = 6'd4;
					5'b00000: lookup = 6'd5;
					5'b00001: lookup = 6'd6;
					5'b00011: lookup = 6'd7;
					5'b00111: lookup = 6'd8;
					5'b01111: lookup = 6'd9;
					default:  lookup = CHAR_BLANK;
				endcase
			end
			default: lookup = CHAR_BLANK;
		endcase
	end

	// Strobe and code leave on the same edge
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n)
			code_valid <= 1'b0;
		else
			code_valid <= letter_done;
	end

	always_ff @(posedge CLOCK_50) begin
		if (letter_done)
			code <= lookup;
	end

endmodule

// ==== morse_keyer.sv ====
//////////////////////////////
// Key timing FSM
// Classes presses, builds the pattern, closes letters on long gaps
//////////////////////////////
`include "morse_settings.svh"

module morse_keyer (
	input  logic                   CLOCK_50,
	input  logic                   rst_n,
	input  logic                   tick,
	input  logic                   key,         // Active low button
	output morse_pkg::letter_t     letter,
	output logic                   letter_done,
	output morse_pkg::press_mark_t mark
);
	import morse_pkg::*;

	// Press count saturates one past the dash limit
	localparam int PRESS_W = $clog2(`MORSE_DASH_TICKS + 2);
	localparam int GAP_W   = $clog2(`MORSE_GAP_TICKS + 2);

	localparam logic [PRESS_W-1:0] PRESS_MAX  = PRESS_W'(`MORSE_DASH_TICKS + 1);
	localparam logic [PRESS_W-1:0] DASH_LIMIT = PRESS_W'(`MORSE_DASH_TICKS);
	localparam logic [GAP_W-1:0]   GAP_LIMIT  = GAP_W'(`MORSE_GAP_TICKS);
	localparam sym_count_t         SYM_MAX    = sym_count_t'(`MORSE_MAX_SYMBOLS);

	typedef enum logic [1:0] {
		ST_IDLE,  // Waiting for first press
		ST_PRESS, // Key held
		ST_GAP    // Key released inside a letter
	} state_t;

	state_t             state;
	logic [PRESS_W-1:0] press_cnt;
	logic [GAP_W-1:0]   gap_cnt;
	pattern_t           pattern;
	sym_count_t         sym_cnt;
	logic               is_dash;
	logic               gap_end;
	logic               room;

	assign is_dash = (press_cnt > DASH_LIMIT);
	assign gap_end = (gap_cnt == GAP_LIMIT); // Next gap tick would pass the limit
	assign room    = (sym_cnt < SYM_MAX);    // Extra symbols dropped

	// Strobe sits on the letter-ending tick itself
	assign letter_done = tick & (state == ST_GAP) & key & gap_end;

	assign letter = '{pattern: pattern, count: sym_cnt};

	////////////////////////////// Control

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			press_cnt <= '0;
			gap_cnt   <= '0;
			sym_cnt   <= '0;
			mark      <= '0;
		end else if (tick) begin
			case (state)
				ST_IDLE: begin
					if (!key) begin // New letter
						state     <= ST_PRESS;
						press_cnt <= PRESS_W'(1);
						sym_cnt   <= '0;
					end
				end
				ST_PRESS: begin
					if (!key) begin
						if (press_cnt != PRESS_MAX)
							press_cnt <= press_cnt + 1'b1;
					end else begin // Release ends the symbol
						state         <= ST_GAP;
						gap_cnt       <= '0;
						mark.is_long  <= is_dash;
						mark.is_short <= ~is_dash;
						if (room)
							sym_cnt <= sym_cnt + 1'b1;
					end
				end
				ST_GAP: begin
					if (!key) begin // Same letter goes on
						state     <= ST_PRESS;
						press_cnt <= PRESS_W'(1);
					end else if (gap_end) begin
						state <= ST_IDLE; // Letter handed off
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////// Pattern

	always_ff @(posedge CLOCK_50) begin
		if (tick) begin
			if (state == ST_IDLE && !key)
				pattern <= '0; // Fresh letter
			else if (state == ST_PRESS && key && room)
				pattern[sym_cnt] <= is_dash;
		end
	end

endmodule

// ==== morse_tick_gen.sv ====
//////////////////////////////
// Slow keying tick from CLOCK_50
//////////////////////////////
`include "morse_settings.svh"

module morse_tick_gen #(
	parameter int unsigned tick_div = `MORSE_TICK_DIV
) (
	input  logic CLOCK_50,
	input  logic rst_n,
	output logic tick
);

	// Counter wide enough for tick_div-1
	localparam int CW = (tick_div > 1) ? $clog2(tick_div) : 1;

	logic [CW-1:0] cnt;
	logic          wrap;

	assign wrap = (cnt == CW'(tick_div - 1)); // Last cycle of the period

	// Clock enable instead of a derived clock
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else begin
			tick <= wrap; // One cycle wide
			if (wrap)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

// ==== seg_pkg.sv ====
//////////////////////////////
// Display types and the character font
//////////////////////////////
`include "morse_settings.svh"

package seg_pkg;

	// Active low, bit 0 = a ... bit 6 = g
	typedef logic [6:0] seg_t;

	// Element 0 drives HEX0
	typedef seg_t [`HEX_DIGITS-1:0] hex_bank_t;

	// Indexed by char code
	localparam seg_t FONT [37] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, // 0 1 2 3 4
		7'h12, 7'h02, 7'h78, 7'h00, 7'h10, // 5 6 7 8 9
		7'h08, 7'h03, 7'h46, 7'h21, 7'h06, // A b C d E
		7'h0E, 7'h42, 7'h09, 7'h4F, 7'h61, // F G H I J
		7'h0A, 7'h47, 7'h6A, 7'h2B, 7'h23, // K L M n o
		7'h0C, 7'h18, 7'h2F, 7'h12, 7'h07, // P q r S t
		7'h41, 7'h63, 7'h55, 7'h09, 7'h11, // U v W X y
		7'h24,                             // Z, drawn like 2
		7'h7F                              // Blank, all segments off
	};

endpackage

// ==== morse_pkg.sv ====
//////////////////////////////
// Keying and code types
// Pattern, symbol count, captured letter, char code, press mark
//////////////////////////////
`include "morse_settings.svh"

package morse_pkg;

	////////////////////////////// Keying

	// Bit i is symbol i in keying order, 1 = dash
	typedef logic [`MORSE_MAX_SYMBOLS-1:0] pattern_t;

	// 0 to 5 symbols held
	typedef logic [2:0] sym_count_t;

	// One captured letter, 8 bits
	typedef struct packed {
		pattern_t   pattern;
		sym_count_t count;
	} letter_t;

	////////////////////////////// Codes

	// 0..9 digits, 10..35 A..Z
	typedef logic [5:0] char_code_t;

	localparam char_code_t CHAR_BLANK = 6'd36; // Dark digit

	// Last press class, is_short lands on bit 0 like LEDR[0]
	typedef struct packed {
		logic is_long;
		logic is_short;
	} press_mark_t;

endpackage

// ==== morse_settings.svh ====
//////////////////////////////
// Timing thresholds and sizes for the Morse key decoder
// Tick divider, dash and gap limits, symbol and digit counts
//////////////////////////////
`ifndef MORSE_SETTINGS_SVH
`define MORSE_SETTINGS_SVH

// CLOCK_50 cycles per keying tick, about 84 ms
`define MORSE_TICK_DIV 4194304

// Press longer than this many ticks is a dash
`define MORSE_DASH_TICKS 4

// Release longer than this many ticks closes the letter
`define MORSE_GAP_TICKS 4

// Longest pattern kept per letter
`define MORSE_MAX_SYMBOLS 5

// Seven-segment digits on the board
`define HEX_DIGITS 6

`endif
